// File: common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction state register and its fields
`define CPU_ISR_W    16
`define CPU_OPC_W    6
`define CPU_MODE_W   2
`define CPU_REG_W    3
`define CPU_NUM_REGS 8

// sequencer phase and datapath control groups
`define CPU_PHASE_W  4
`define CPU_ALU_W    5
`define CPU_SFT_W    7

`endif

// File: common/ctrl_pkg.sv
`include "cpu_config.svh"

package ctrl_pkg;

    // one step of the sequencer, idle means no step
    typedef enum logic [`CPU_PHASE_W-1:0] {
        PH_IDLE = 4'd0,
        PH_IF0  = 4'd1,
        PH_IF1  = 4'd2,
        PH_FF0  = 4'd3,
        PH_FF1  = 4'd4,
        PH_FF2  = 4'd5,
        PH_TF0  = 4'd6,
        PH_TF1  = 4'd7,
        PH_EX0  = 4'd8,
        PH_EX1  = 4'd9
    } phase_e;

    typedef struct packed {
        logic x;
        logic y;
        logic z;
        logic u;
        logic v;
    } alu_ctrl_t;

    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic r;
        logic l;
    } sft_ctrl_t;

endpackage

// File: common/decode_if.sv
`include "cpu_config.svh"

// one decoded step: instruction fields plus the phase it runs in
interface decode_if;

    isr_pkg::opcode_e       op;
    isr_pkg::mode_e         src_mode;
    logic [`CPU_REG_W-1:0]  src_reg;
    isr_pkg::mode_e         dst_mode;
    logic [`CPU_REG_W-1:0]  dst_reg;
    ctrl_pkg::phase_e       phase;

    modport drive (
        output op, src_mode, src_reg,
        output dst_mode, dst_reg, phase
    );

    modport sink (
        input op, src_mode, src_reg,
        input dst_mode, dst_reg, phase
    );

endinterface

// File: common/isr_pkg.sv
`include "cpu_config.svh"

package isr_pkg;

    // execute opcode, values follow the instruction table
    typedef enum logic [`CPU_OPC_W-1:0] {
        OP_HLT  = 6'b000000,
        OP_CLR  = 6'b000100,
        OP_ASL  = 6'b001000,
        OP_ASR  = 6'b001001,
        OP_RLC  = 6'b001010,
        OP_RRC  = 6'b001011,
        OP_LSL  = 6'b001100,
        OP_LSR  = 6'b001101,
        OP_ROL  = 6'b001110,
        OP_ROR  = 6'b001111,
        OP_MOV  = 6'b010000,
        OP_JMP  = 6'b010001,
        OP_RET  = 6'b010010,
        OP_RIT  = 6'b010011,
        OP_ADD  = 6'b010100,
        OP_RJP  = 6'b010101,
        OP_ADC  = 6'b010110,
        OP_SUB  = 6'b011000,
        OP_SBC  = 6'b011010,
        OP_CMP  = 6'b011011,
        // whole 0111xx group
        OP_NOP  = 6'b011100,
        OP_OR   = 6'b100000,
        OP_XOR  = 6'b100001,
        OP_AND  = 6'b100010,
        OP_BIT  = 6'b100011,
        OP_JSR  = 6'b101100,
        OP_RJS  = 6'b101101,
        OP_SVC  = 6'b101110,
        OP_BRN  = 6'b110000,
        OP_BRZ  = 6'b110001,
        OP_BRV  = 6'b110010,
        OP_BRC  = 6'b110011,
        OP_RBN  = 6'b111000,
        OP_RBZ  = 6'b111001,
        OP_RBV  = 6'b111010,
        OP_RBC  = 6'b111011,
        // any code not listed above
        OP_NONE = 6'b111111
    } opcode_e;

    typedef enum logic [`CPU_MODE_W-1:0] {
        MODE_D  = 2'b00,
        MODE_I  = 2'b01,
        MODE_MI = 2'b10,
        MODE_IP = 2'b11
    } mode_e;

endpackage

// File: decoder/datapath_ctrl_decoder.sv
module datapath_ctrl_decoder (
    decode_if.sink                 dec,
    input  logic                   psw_c,
    output logic                   mda,
    output logic                   b0b,
    output logic                   smd,
    output logic                   sma,
    output logic                   sb0,
    output logic                   als,
    output logic                   shs,
    output ctrl_pkg::alu_ctrl_t    alu,
    output ctrl_pkg::sft_ctrl_t    sft
);

    logic if0, if1, ff0, ff1, ff2, tf0, tf1, ex0, ex1;
    logic fetch_all, fetch_alu;
    logic op_shift, op_arith, op_logic, op_jump, op_call, op_br, op_rb;
    logic op_clr, op_mov;

    assign if0 = (dec.phase == ctrl_pkg::PH_IF0);
    assign if1 = (dec.phase == ctrl_pkg::PH_IF1);
    assign ff0 = (dec.phase == ctrl_pkg::PH_FF0);
    assign ff1 = (dec.phase == ctrl_pkg::PH_FF1);
    assign ff2 = (dec.phase == ctrl_pkg::PH_FF2);
    assign tf0 = (dec.phase == ctrl_pkg::PH_TF0);
    assign tf1 = (dec.phase == ctrl_pkg::PH_TF1);
    assign ex0 = (dec.phase == ctrl_pkg::PH_EX0);
    assign ex1 = (dec.phase == ctrl_pkg::PH_EX1);

    assign fetch_all = if0 | if1 | ff0 | ff1 | ff2 | tf0 | tf1;
    // ff1 only latches, the alu passes nothing
    assign fetch_alu = if0 | if1 | ff0 | ff2 | tf0 | tf1;

    // opcode classes only count during execute
    assign op_clr   = ex0 & (dec.op == isr_pkg::OP_CLR);
    assign op_mov   = ex0 & (dec.op == isr_pkg::OP_MOV);
    assign op_shift = ex0 & (dec.op inside {
        isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_LSL, isr_pkg::OP_LSR,
        isr_pkg::OP_ROL, isr_pkg::OP_ROR, isr_pkg::OP_RLC, isr_pkg::OP_RRC});
    assign op_arith = ex0 & (dec.op inside {
        isr_pkg::OP_ADD, isr_pkg::OP_ADC, isr_pkg::OP_RJP,
        isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_CMP});
    assign op_logic = ex0 & (dec.op inside {
        isr_pkg::OP_OR, isr_pkg::OP_XOR, isr_pkg::OP_AND, isr_pkg::OP_BIT});
    assign op_jump  = ex0 & (dec.op inside {
        isr_pkg::OP_JMP, isr_pkg::OP_RET, isr_pkg::OP_RIT});
    assign op_call  = ex0 & (dec.op inside {
        isr_pkg::OP_JSR, isr_pkg::OP_RJS, isr_pkg::OP_SVC});
    assign op_br    = ex0 & (dec.op inside {
        isr_pkg::OP_BRN, isr_pkg::OP_BRZ, isr_pkg::OP_BRV, isr_pkg::OP_BRC});
    assign op_rb    = ex0 & (dec.op inside {
        isr_pkg::OP_RBN, isr_pkg::OP_RBZ, isr_pkg::OP_RBV, isr_pkg::OP_RBC});

    // bus strobes
    assign mda = ff2 | op_shift | op_arith | op_logic | op_rb;
    assign b0b = op_mov | op_jump | op_arith | op_logic | op_call | op_br | op_rb | ex1;
    assign smd = if0 | ff0 | tf0 | op_clr | op_shift | op_mov | op_call |
                 (op_arith & (dec.op != isr_pkg::OP_CMP)) |
                 (op_logic & (dec.op != isr_pkg::OP_BIT));
    assign sma = if0 | ff0 | tf0;
    assign sb0 = ff2;
    assign als = fetch_all | op_clr | op_mov | op_jump | op_arith | op_logic |
                 op_call | op_br | op_rb | ex1;

    // alu function select
    assign alu.x = (ff0 & (dec.src_mode == isr_pkg::MODE_MI)) |
                   (ex0 & (dec.op inside {isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_CMP}));
    assign alu.y = fetch_alu | op_mov | op_jump | op_arith | op_call | op_br | ex1;
    assign alu.z = (ex0 & (dec.op == isr_pkg::OP_OR)) | op_rb;
    // carry in, adc and sbc take it from the psw
    assign alu.u = if1 | tf1 |
                   (ex0 & (dec.op inside {isr_pkg::OP_SUB, isr_pkg::OP_CMP})) |
                   (ex0 & psw_c & (dec.op inside {isr_pkg::OP_ADC, isr_pkg::OP_SBC}));
    assign alu.v = fetch_alu | op_mov | op_jump | op_arith | op_call | op_br | op_rb |
                   (ex0 & (dec.op == isr_pkg::OP_XOR)) | ex1;

    assign shs = op_shift;

    // shifter pattern per shift opcode
    assign sft.a = ex0 & (dec.op == isr_pkg::OP_ASR);
    assign sft.b = ex0 & (dec.op == isr_pkg::OP_ROL);
    assign sft.c = ex0 & (dec.op inside {isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_RLC});
    assign sft.d = ex0 & (dec.op == isr_pkg::OP_ROR);
    assign sft.e = ex0 & (dec.op inside {isr_pkg::OP_RLC, isr_pkg::OP_RRC});
    assign sft.r = ex0 & (dec.op inside {isr_pkg::OP_ASR, isr_pkg::OP_ROR, isr_pkg::OP_RRC});
    assign sft.l = ex0 & (dec.op inside {
        isr_pkg::OP_ASR, isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_RLC});

endmodule

// File: decoder/op_decoder.sv
`include "cpu_config.svh"

module op_decoder (
    input  logic [`CPU_ISR_W-1:0] isr,
    input  ctrl_pkg::phase_e      phase,
    decode_if.drive               dec
);

    // field positions, opcode on top, destination at the bottom
    localparam int OPC_LSB  = `CPU_ISR_W - `CPU_OPC_W;
    localparam int SMOD_LSB = OPC_LSB - `CPU_MODE_W;
    localparam int SREG_LSB = SMOD_LSB - `CPU_REG_W;
    localparam int DMOD_LSB = SREG_LSB - `CPU_MODE_W;
    localparam int DREG_LSB = DMOD_LSB - `CPU_REG_W;

    logic [`CPU_OPC_W-1:0] opc;

    assign opc = isr[`CPU_ISR_W-1 -: `CPU_OPC_W];

    assign dec.src_mode = isr_pkg::mode_e'(isr[SMOD_LSB +: `CPU_MODE_W]);
    assign dec.src_reg  = isr[SREG_LSB +: `CPU_REG_W];
    assign dec.dst_mode = isr_pkg::mode_e'(isr[DMOD_LSB +: `CPU_MODE_W]);
    assign dec.dst_reg  = isr[DREG_LSB +: `CPU_REG_W];

    // phase rides along so the bundle is a complete step
    assign dec.phase = phase;

    always_comb begin
        casez (opc)
            // nop group folds to a single code
            6'b0111??: dec.op = isr_pkg::OP_NOP;
            6'b000000,
            6'b000100,
            6'b001???,
            6'b0100??,
            6'b010100,
            6'b010101,
            6'b010110,
            6'b011000,
            6'b011010,
            6'b011011,
            6'b1000??,
            6'b101100,
            6'b101101,
            6'b101110,
            6'b1100??,
            6'b1110??: dec.op = isr_pkg::opcode_e'(opc);
            // mul and the unassigned codes
            default:   dec.op = isr_pkg::OP_NONE;
        endcase
    end

endmodule

// File: decoder/reg_select_decoder.sv
`include "cpu_config.svh"

module reg_select_decoder (
    decode_if.sink                  dec,
    input  logic                    psw_n,
    input  logic                    psw_z,
    input  logic                    psw_v,
    input  logic                    psw_c,
    output logic [`CPU_NUM_REGS-1:0] r_a,
    output logic [`CPU_NUM_REGS-1:0] s_r
);

    localparam int N = `CPU_NUM_REGS;

    logic [N-1:0] src_oh;
    logic [N-1:0] dst_oh;
    logic         if0, if1, ff0, ff1, tf0, tf1, ex0, ex1;
    logic         src_ip, dst_ip, dst_d;
    logic         op_wb, op_psw, op_jump, op_call, br_taken;

    assign src_oh = {{(N-1){1'b0}}, 1'b1} << dec.src_reg;
    assign dst_oh = {{(N-1){1'b0}}, 1'b1} << dec.dst_reg;

    assign if0 = (dec.phase == ctrl_pkg::PH_IF0);
    assign if1 = (dec.phase == ctrl_pkg::PH_IF1);
    assign ff0 = (dec.phase == ctrl_pkg::PH_FF0);
    assign ff1 = (dec.phase == ctrl_pkg::PH_FF1);
    assign tf0 = (dec.phase == ctrl_pkg::PH_TF0);
    assign tf1 = (dec.phase == ctrl_pkg::PH_TF1);
    assign ex0 = (dec.phase == ctrl_pkg::PH_EX0);
    assign ex1 = (dec.phase == ctrl_pkg::PH_EX1);

    assign src_ip = (dec.src_mode == isr_pkg::MODE_IP);
    assign dst_ip = (dec.dst_mode == isr_pkg::MODE_IP);
    assign dst_d  = (dec.dst_mode == isr_pkg::MODE_D);

    // opcodes that write their result back to the destination
    assign op_wb = dec.op inside {
        isr_pkg::OP_CLR, isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_LSL,
        isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_ROR, isr_pkg::OP_RLC,
        isr_pkg::OP_RRC, isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_ADC,
        isr_pkg::OP_RJP, isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_OR,
        isr_pkg::OP_XOR, isr_pkg::OP_AND
    };

    // r5 slot doubles as the psw write strobe
    assign op_psw = dec.op inside {
        isr_pkg::OP_CLR, isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_LSL,
        isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_ROR, isr_pkg::OP_RLC,
        isr_pkg::OP_RRC, isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_ADC,
        isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_CMP, isr_pkg::OP_OR,
        isr_pkg::OP_XOR, isr_pkg::OP_AND, isr_pkg::OP_BIT
    };

    assign op_jump = dec.op inside {isr_pkg::OP_JMP, isr_pkg::OP_RET, isr_pkg::OP_RIT};
    assign op_call = dec.op inside {isr_pkg::OP_JSR, isr_pkg::OP_RJS, isr_pkg::OP_SVC};

    // absolute and relative branches share the flag test
    assign br_taken =
        (psw_n & (dec.op inside {isr_pkg::OP_BRN, isr_pkg::OP_RBN})) |
        (psw_z & (dec.op inside {isr_pkg::OP_BRZ, isr_pkg::OP_RBZ})) |
        (psw_v & (dec.op inside {isr_pkg::OP_BRV, isr_pkg::OP_RBV})) |
        (psw_c & (dec.op inside {isr_pkg::OP_BRC, isr_pkg::OP_RBC}));

    always_comb begin
        r_a = ({N{ff0}} & src_oh) |
              ({N{ff1 & src_ip}} & src_oh) |
              ({N{tf0}} & dst_oh) |
              ({N{tf1 & dst_ip}} & dst_oh);
        // stack pointer and pc
        r_a[6] = r_a[6] | (ex0 & (dec.op inside {isr_pkg::OP_RET, isr_pkg::OP_RIT}));
        r_a[7] = r_a[7] | if0 | if1 | (ex1 & (dec.op == isr_pkg::OP_RJS));

        s_r = ({N{ff0}} & src_oh) |
              ({N{ff1 & src_ip}} & src_oh) |
              ({N{tf1 & dst_ip}} & dst_oh) |
              ({N{ex0 & op_wb & dst_d}} & dst_oh);
        s_r[5] = ex0 & op_psw;
        s_r[7] = s_r[7] | if1 | (ex0 & (op_jump | br_taken)) | (ex1 & op_call);
    end

endmodule

// File: design/control_decoder.sv
`include "cpu_config.svh"

module control_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CPU_ISR_W-1:0]     isr,
    input  ctrl_pkg::phase_e          phase,
    input  logic                      psw_n,
    input  logic                      psw_z,
    input  logic                      psw_v,
    input  logic                      psw_c,
    output logic [`CPU_NUM_REGS-1:0]  r_a,
    output logic [`CPU_NUM_REGS-1:0]  s_r,
    output logic                      mda,
    output logic                      b0b,
    output logic                      smd,
    output logic                      sma,
    output logic                      sb0,
    output logic                      als,
    output logic                      shs,
    output ctrl_pkg::alu_ctrl_t       alu_ctrl,
    output ctrl_pkg::sft_ctrl_t       sft_ctrl,
    output isr_pkg::opcode_e          op
);

    // register selects, seven strobes, alu and shifter controls
    localparam int CW_W = 2 * `CPU_NUM_REGS + 7 + `CPU_ALU_W + `CPU_SFT_W;

    logic [`CPU_NUM_REGS-1:0] r_a_d;
    logic [`CPU_NUM_REGS-1:0] s_r_d;
    logic                     mda_d, b0b_d, smd_d, sma_d, sb0_d, als_d, shs_d;
    ctrl_pkg::alu_ctrl_t      alu_d;
    ctrl_pkg::sft_ctrl_t      sft_d;
    logic [CW_W-1:0]          cw_d;
    logic [CW_W-1:0]          cw_q;
    isr_pkg::opcode_e         op_q;

    decode_if dec ();

    op_decoder u_op_decoder (
        .isr   (isr),
        .phase (phase),
        .dec   (dec.drive)
    );

    reg_select_decoder u_reg_select_decoder (
        .dec   (dec.sink),
        .psw_n (psw_n),
        .psw_z (psw_z),
        .psw_v (psw_v),
        .psw_c (psw_c),
        .r_a   (r_a_d),
        .s_r   (s_r_d)
    );

    datapath_ctrl_decoder u_datapath_ctrl_decoder (
        .dec   (dec.sink),
        .psw_c (psw_c),
        .mda   (mda_d),
        .b0b   (b0b_d),
        .smd   (smd_d),
        .sma   (sma_d),
        .sb0   (sb0_d),
        .als   (als_d),
        .shs   (shs_d),
        .alu   (alu_d),
        .sft   (sft_d)
    );

    assign cw_d = {r_a_d, s_r_d, mda_d, b0b_d, smd_d, sma_d, sb0_d, als_d, shs_d,
                   alu_d, sft_d};

    // one decode per cycle, idle phase gives an empty word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cw_q <= '0;
            op_q <= isr_pkg::OP_NONE;
        end else begin
            cw_q <= cw_d;
            op_q <= dec.op;
        end
    end

    assign {r_a, s_r, mda, b0b, smd, sma, sb0, als, shs, alu_ctrl, sft_ctrl} = cw_q;
    assign op = op_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the control decoder testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_control_decoder \
    -o tb_control_decoder > build.log 2>&1 \
    && ./obj_dir/tb_control_decoder > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "simulation FAILED"; exit 1; }

grep -qx "Everything OK" sim.log \
    && echo "simulation PASSED" \
    || { cat sim.log; echo "simulation FAILED"; exit 1; }

// File: verif/tb_control_decoder.sv
`include "cpu_config.svh"

module tb_control_decoder;

    timeunit 1ns;
    timeprecision 100ps;

    // all tests together take about 150 cycles
    localparam int MAX_CYCLES = 400;

    logic                     clk;
    logic                     rst_n;
    logic [`CPU_ISR_W-1:0]    isr;
    ctrl_pkg::phase_e         phase;
    logic                     psw_n, psw_z, psw_v, psw_c;
    logic [`CPU_NUM_REGS-1:0] r_a;
    logic [`CPU_NUM_REGS-1:0] s_r;
    logic                     mda, b0b, smd, sma, sb0, als, shs;
    ctrl_pkg::alu_ctrl_t      alu_ctrl;
    ctrl_pkg::sft_ctrl_t      sft_ctrl;
    isr_pkg::opcode_e         op;
    logic [31:0]              lfsr_state = 32'hd4f213bf;
    int                       cycles = 0;

    control_decoder dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .isr      (isr),
        .phase    (phase),
        .psw_n    (psw_n),
        .psw_z    (psw_z),
        .psw_v    (psw_v),
        .psw_c    (psw_c),
        .r_a      (r_a),
        .s_r      (s_r),
        .mda      (mda),
        .b0b      (b0b),
        .smd      (smd),
        .sma      (sma),
        .sb0      (sb0),
        .als      (als),
        .shs      (shs),
        .alu_ctrl (alu_ctrl),
        .sft_ctrl (sft_ctrl),
        .op       (op)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [63:0] control_word();
        return 64'({r_a, s_r, mda, b0b, smd, sma, sb0, als, shs, alu_ctrl, sft_ctrl});
    endfunction

    function automatic logic is_shift(input isr_pkg::opcode_e o);
        case (o)
            isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_RLC, isr_pkg::OP_RRC,
            isr_pkg::OP_LSL, isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_ROR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_wb(input isr_pkg::opcode_e o);
        case (o)
            isr_pkg::OP_CLR, isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_ADC,
            isr_pkg::OP_RJP, isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_OR,
            isr_pkg::OP_XOR, isr_pkg::OP_AND: return 1'b1;
            default: return is_shift(o);
        endcase
    endfunction

    function automatic logic is_psw(input isr_pkg::opcode_e o);
        case (o)
            isr_pkg::OP_CLR, isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_ADC,
            isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_CMP, isr_pkg::OP_OR,
            isr_pkg::OP_XOR, isr_pkg::OP_AND, isr_pkg::OP_BIT: return 1'b1;
            default: return is_shift(o);
        endcase
    endfunction

    // flags ordered n, z, v, c
    function automatic logic branch_taken(input isr_pkg::opcode_e o, input logic [3:0] f);
        case (o)
            isr_pkg::OP_BRN, isr_pkg::OP_RBN: return f[3];
            isr_pkg::OP_BRZ, isr_pkg::OP_RBZ: return f[2];
            isr_pkg::OP_BRV, isr_pkg::OP_RBV: return f[1];
            isr_pkg::OP_BRC, isr_pkg::OP_RBC: return f[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [7:0] exp_r_a(input ctrl_pkg::phase_e p, input isr_pkg::mode_e sm,
                                           input logic [2:0] sr, input isr_pkg::mode_e dm,
                                           input logic [2:0] dr, input isr_pkg::opcode_e o);
        logic [7:0] v;
        v = 8'h00;
        case (p)
            ctrl_pkg::PH_IF0, ctrl_pkg::PH_IF1: v[7] = 1'b1;
            ctrl_pkg::PH_FF0: v[sr] = 1'b1;
            ctrl_pkg::PH_FF1: if (sm == isr_pkg::MODE_IP) v[sr] = 1'b1;
            ctrl_pkg::PH_TF0: v[dr] = 1'b1;
            ctrl_pkg::PH_TF1: if (dm == isr_pkg::MODE_IP) v[dr] = 1'b1;
            ctrl_pkg::PH_EX0: if (o == isr_pkg::OP_RET || o == isr_pkg::OP_RIT) v[6] = 1'b1;
            ctrl_pkg::PH_EX1: if (o == isr_pkg::OP_RJS) v[7] = 1'b1;
            default: v = 8'h00;
        endcase
        return v;
    endfunction

    function automatic logic [7:0] exp_s_r(input ctrl_pkg::phase_e p, input isr_pkg::mode_e sm,
                                           input logic [2:0] sr, input isr_pkg::mode_e dm,
                                           input logic [2:0] dr, input isr_pkg::opcode_e o,
                                           input logic [3:0] f);
        logic [7:0] v;
        v = 8'h00;
        case (p)
            ctrl_pkg::PH_IF1: v[7] = 1'b1;
            ctrl_pkg::PH_FF0: v[sr] = 1'b1;
            ctrl_pkg::PH_FF1: if (sm == isr_pkg::MODE_IP) v[sr] = 1'b1;
            ctrl_pkg::PH_TF1: if (dm == isr_pkg::MODE_IP) v[dr] = 1'b1;
            ctrl_pkg::PH_EX0: begin
                if (is_wb(o) && dm == isr_pkg::MODE_D) v[dr] = 1'b1;
                if (o == isr_pkg::OP_JMP || o == isr_pkg::OP_RET || o == isr_pkg::OP_RIT)
                    v[7] = 1'b1;
                if (branch_taken(o, f)) v[7] = 1'b1;
            end
            ctrl_pkg::PH_EX1:
                if (o == isr_pkg::OP_JSR || o == isr_pkg::OP_RJS || o == isr_pkg::OP_SVC)
                    v[7] = 1'b1;
            default: v = 8'h00;
        endcase
        // bit 5 is only ever the psw write
        v[5] = (p == ctrl_pkg::PH_EX0) && is_psw(o);
        return v;
    endfunction

    function automatic logic [6:0] exp_sft(input isr_pkg::opcode_e o);
        logic a, b, c, d, e, r, l;
        a = (o == isr_pkg::OP_ASR);
        b = (o == isr_pkg::OP_ROL);
        c = (o == isr_pkg::OP_LSR) || (o == isr_pkg::OP_ROL) || (o == isr_pkg::OP_RLC);
        d = (o == isr_pkg::OP_ROR);
        e = (o == isr_pkg::OP_RLC) || (o == isr_pkg::OP_RRC);
        r = (o == isr_pkg::OP_ASR) || (o == isr_pkg::OP_ROR) || (o == isr_pkg::OP_RRC);
        l = (o == isr_pkg::OP_ASR) || (o == isr_pkg::OP_LSR) || (o == isr_pkg::OP_ROL) ||
            (o == isr_pkg::OP_RLC);
        return {a, b, c, d, e, r, l};
    endfunction

    // called 2 ns after an edge, returns 2 ns after the edge that latched the step
    task automatic drive(input logic [15:0] i, input ctrl_pkg::phase_e p, input logic [3:0] f);
        isr = i;
        phase = p;
        {psw_n, psw_z, psw_v, psw_c} = f;
        @(posedge clk);
        #2;
    endtask

    task automatic step_and_check(input isr_pkg::opcode_e o, input isr_pkg::mode_e sm,
                                  input logic [2:0] sr, input isr_pkg::mode_e dm,
                                  input logic [2:0] dr, input ctrl_pkg::phase_e p,
                                  input logic [3:0] f, input string msg);
        drive({o, sm, sr, dm, dr}, p, f);
        check(64'(r_a), 64'(exp_r_a(p, sm, sr, dm, dr, o)), {msg, ": r_a"});
        check(64'(s_r), 64'(exp_s_r(p, sm, sr, dm, dr, o, f)), {msg, ": s_r"});
        check(64'(op), 64'(o), {msg, ": op"});
    endtask

    task automatic reset_state();
        check(control_word(), 64'(0), "control word during reset");
        check(64'(op), 64'(isr_pkg::OP_NONE), "op during reset");
        rst_n = 1'b1;
        drive(16'h5a5a, ctrl_pkg::PH_IDLE, 4'hf);
        check(control_word(), 64'(0), "control word for an idle step");
    endtask

    task automatic fetch_phases();
        ctrl_pkg::phase_e seq[7];
        logic [7:0]       rv;
        isr_pkg::mode_e   sm, dm;
        logic [2:0]       sr, dr;
        seq = '{ctrl_pkg::PH_IF0, ctrl_pkg::PH_IF1, ctrl_pkg::PH_FF0, ctrl_pkg::PH_FF1,
                ctrl_pkg::PH_FF2, ctrl_pkg::PH_TF0, ctrl_pkg::PH_TF1};
        for (int k = 0; k < 8; k++) begin
            rand_bits(5, rv);
            sm = isr_pkg::mode_e'(rv[4:3]);
            sr = rv[2:0];
            rand_bits(5, rv);
            dm = isr_pkg::mode_e'(rv[4:3]);
            dr = rv[2:0];
            // every other pass uses post-increment on both sides
            if (k[0]) begin
                sm = isr_pkg::MODE_IP;
                dm = isr_pkg::MODE_IP;
            end
            foreach (seq[j]) begin
                step_and_check(isr_pkg::OP_MOV, sm, sr, dm, dr, seq[j], 4'h0, "fetch phase");
                check(64'(sb0), 64'(seq[j] == ctrl_pkg::PH_FF2), "sb0 only in FF2");
            end
        end
    endtask

    task automatic writeback_psw();
        isr_pkg::opcode_e ops[20];
        logic [7:0]       rv;
        logic             carry_op;
        ops = '{isr_pkg::OP_CLR, isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_RLC,
                isr_pkg::OP_RRC, isr_pkg::OP_LSL, isr_pkg::OP_LSR, isr_pkg::OP_ROL,
                isr_pkg::OP_ROR, isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_ADC,
                isr_pkg::OP_RJP, isr_pkg::OP_SUB, isr_pkg::OP_SBC, isr_pkg::OP_OR,
                isr_pkg::OP_XOR, isr_pkg::OP_AND, isr_pkg::OP_CMP, isr_pkg::OP_BIT};
        foreach (ops[k]) begin
            carry_op = (ops[k] == isr_pkg::OP_ADC) || (ops[k] == isr_pkg::OP_SBC);
            rand_bits(3, rv);
            step_and_check(ops[k], isr_pkg::MODE_D, 3'd0, isr_pkg::MODE_D, rv[2:0],
                           ctrl_pkg::PH_EX0, 4'h1, "write-back direct");
            if (carry_op)
                check(64'(alu_ctrl.u), 64'(1), "carry in with psw_c set");
            step_and_check(ops[k], isr_pkg::MODE_D, 3'd0, isr_pkg::MODE_MI, rv[2:0],
                           ctrl_pkg::PH_EX0, 4'h0, "write-back indirect");
            if (carry_op)
                check(64'(alu_ctrl.u), 64'(0), "carry in with psw_c clear");
        end
    endtask

    task automatic branches();
        isr_pkg::opcode_e ops[8];
        logic [5:0]       code;
        logic [3:0]       mask;
        ops = '{isr_pkg::OP_BRN, isr_pkg::OP_BRZ, isr_pkg::OP_BRV, isr_pkg::OP_BRC,
                isr_pkg::OP_RBN, isr_pkg::OP_RBZ, isr_pkg::OP_RBV, isr_pkg::OP_RBC};
        foreach (ops[k]) begin
            code = ops[k];
            mask = 4'b1000 >> code[1:0];
            step_and_check(ops[k], isr_pkg::MODE_D, 3'd1, isr_pkg::MODE_D, 3'd2,
                           ctrl_pkg::PH_EX0, mask, "branch flag set");
            check(64'(s_r[7]), 64'(1), "branch taken");
            // all other flags set, the tested one clear
            step_and_check(ops[k], isr_pkg::MODE_D, 3'd1, isr_pkg::MODE_D, 3'd2,
                           ctrl_pkg::PH_EX0, ~mask, "branch flag clear");
            check(64'(s_r[7]), 64'(0), "branch not taken");
        end
    endtask

    task automatic shifts_and_class();
        isr_pkg::opcode_e ops[8];
        logic [5:0]       odd_codes[8];
        ops = '{isr_pkg::OP_ASL, isr_pkg::OP_ASR, isr_pkg::OP_RLC, isr_pkg::OP_RRC,
                isr_pkg::OP_LSL, isr_pkg::OP_LSR, isr_pkg::OP_ROL, isr_pkg::OP_ROR};
        foreach (ops[k]) begin
            step_and_check(ops[k], isr_pkg::MODE_D, 3'd3, isr_pkg::MODE_D, 3'd4,
                           ctrl_pkg::PH_EX0, 4'h0, "shift");
            check(64'(shs), 64'(1), "shs for a shift");
            check(64'(sft_ctrl), 64'(exp_sft(ops[k])), "shifter pattern");
        end
        // nop group first, then unassigned codes
        odd_codes = '{6'b011100, 6'b011101, 6'b011110, 6'b011111,
                      6'b000001, 6'b100100, 6'b110100, 6'b111111};
        foreach (odd_codes[k]) begin
            drive({odd_codes[k], 10'h0}, ctrl_pkg::PH_EX0, 4'h0);
            check(64'(op), (k < 4) ? 64'(isr_pkg::OP_NOP) : 64'(isr_pkg::OP_NONE),
                  "opcode class");
            check(64'(shs), 64'(0), "shs for a non-shift");
            check(64'(sft_ctrl), 64'(0), "shifter pattern for a non-shift");
            check(64'(s_r), 64'(0), "s_r for a non-writing code");
        end
    endtask

    task automatic back_to_back();
        ctrl_pkg::phase_e seq[8];
        isr_pkg::opcode_e ops[8];
        logic [7:0]       op_bits;
        logic [7:0]       sm_bits;
        logic [7:0]       sr_bits;
        logic [7:0]       dm_bits;
        logic [7:0]       dr_bits;
        logic [7:0]       fv;
        seq = '{ctrl_pkg::PH_FF0, ctrl_pkg::PH_EX0, ctrl_pkg::PH_TF1, ctrl_pkg::PH_EX1,
                ctrl_pkg::PH_IF0, ctrl_pkg::PH_FF1, ctrl_pkg::PH_EX0, ctrl_pkg::PH_TF0};
        ops = '{isr_pkg::OP_MOV, isr_pkg::OP_ADD, isr_pkg::OP_RET, isr_pkg::OP_JSR,
                isr_pkg::OP_RJS, isr_pkg::OP_BRZ, isr_pkg::OP_CMP, isr_pkg::OP_ROL};
        repeat (2) begin
            foreach (seq[k]) begin
                rand_bits(3, op_bits);
                rand_bits(2, sm_bits);
                rand_bits(3, sr_bits);
                rand_bits(2, dm_bits);
                rand_bits(3, dr_bits);
                rand_bits(4, fv);
                step_and_check(ops[op_bits[2:0]], isr_pkg::mode_e'(sm_bits[1:0]),
                               sr_bits[2:0], isr_pkg::mode_e'(dm_bits[1:0]), dr_bits[2:0],
                               seq[k], fv[3:0], "back-to-back step");
            end
        end
        drive(16'h0000, ctrl_pkg::PH_IDLE, 4'h0);
        check(control_word(), 64'(0), "idle after back-to-back steps");
    endtask

    initial begin
        rst_n = 1'b0;
        // a live step while reset is held
        isr = 16'h5a5a;
        phase = ctrl_pkg::PH_IF1;
        psw_n = 1'b0;
        psw_z = 1'b0;
        psw_v = 1'b0;
        psw_c = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset_state();
        fetch_phases();
        writeback_psw();
        branches();
        shifts_and_class();
        back_to_back();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/isr_pkg.sv
common/ctrl_pkg.sv
common/decode_if.sv
decoder/op_decoder.sv
decoder/reg_select_decoder.sv
decoder/datapath_ctrl_decoder.sv
design/control_decoder.sv
verif/tb_control_decoder.sv
